// File: uart_pkg.sv
package uart_pkg;

    // One serial data byte as it travels on the line
    typedef logic [7:0] uart_byte_t;

    localparam int OVERSAMPLE = 16; // Ticks per bit

    // Counts ticks inside one bit; wraps once per bit
    typedef logic [$clog2(OVERSAMPLE)-1:0] tick_cnt_t;

    // Index of a data bit inside a frame
    typedef logic [2:0] bit_idx_t;

endpackage

// File: debug_pkg.sv
package debug_pkg;

    // Processor word as seen by the debug unit
    typedef logic [31:0] word_t;

    localparam int WORD_BYTES = 4;

    // Host command codes
    typedef enum logic [7:0] {
        CMD_DUMP_REGS   = 8'h01,
        CMD_DUMP_IF_ID  = 8'h02,
        CMD_DUMP_ID_EX  = 8'h03,
        CMD_DUMP_EX_MEM = 8'h04,
        CMD_DUMP_MEM_WB = 8'h05,
        CMD_DUMP_MEM    = 8'h06,
        CMD_LOAD_PROG   = 8'h07,
        CMD_MODE_RUN    = 8'h08,
        CMD_MODE_STEP   = 8'h09,
        CMD_STEP        = 8'h0A,
        CMD_SET_ADDR    = 8'h0B
    } cmd_t;

    // Controller FSM states
    typedef enum logic [2:0] {
        IDLE,
        SEND,
        WAIT_TX,
        GET_ADDR,
        LOAD
    } ctrl_state_t;

endpackage

// File: uart_baud_gen.sv
`timescale 1ns/1ps

module uart_baud_gen #(
    parameter int BAUD_DIV = 326
) (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_tick
);

    localparam int CW = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

    logic [CW-1:0] cnt;
    logic          wrap;

    assign wrap = (cnt == CW'(BAUD_DIV - 1));

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else begin
            cnt    <= wrap ? '0 : cnt + CW'(1);
            o_tick <= wrap; // One clock wide
        end
    end

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_tick,
    input  logic       i_rx,
    output logic       o_rx_strobe,
    output uart_byte_t o_rx_byte
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t  state;
    logic [1:0] sync;
    logic       rx_s;
    tick_cnt_t  tick_cnt;
    bit_idx_t   bit_idx;
    uart_byte_t shreg;
    logic       bit_end;

    assign rx_s    = sync[1];
    assign bit_end = i_tick && (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1));
    assign o_rx_byte = shreg;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            sync        <= 2'b11; // Line idles high
            state       <= RX_IDLE;
            tick_cnt    <= '0;
            bit_idx     <= '0;
            o_rx_strobe <= 1'b0;
        end else begin
            sync        <= {sync[0], i_rx};
            o_rx_strobe <= 1'b0;
            if (state != RX_IDLE && i_tick)
                tick_cnt <= tick_cnt + tick_cnt_t'(1);
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_s)
                        state <= RX_START;
                end
                RX_START: begin
                    // Recheck the start bit at its middle, then realign
                    if (i_tick && tick_cnt == tick_cnt_t'(OVERSAMPLE / 2 - 1)) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + bit_idx_t'(1);
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        o_rx_strobe <= rx_s; // Framing error drops the byte
                        state       <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && bit_end)
            shreg <= {rx_s, shreg[7:1]};
    end

    a_strobe_single : assert property (@(posedge i_clk) disable iff (i_reset)
        o_rx_strobe |=> !o_rx_strobe);

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_tick,
    input  logic       i_tx_strobe,
    input  uart_byte_t i_tx_byte,
    output logic       o_tx_busy,
    output logic       o_tx
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t  state;
    tick_cnt_t  tick_cnt;
    bit_idx_t   bit_idx;
    uart_byte_t shreg;
    logic       bit_end;

    assign bit_end   = i_tick && (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1));
    assign o_tx_busy = (state != TX_IDLE); // Rises the cycle after the strobe

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            o_tx     <= 1'b1;
        end else begin
            if (state != TX_IDLE && i_tick)
                tick_cnt <= tick_cnt + tick_cnt_t'(1);
            case (state)
                TX_IDLE: begin
                    tick_cnt <= '0;
                    if (i_tx_strobe) begin
                        o_tx  <= 1'b0; // Start bit
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        o_tx    <= shreg[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            o_tx  <= 1'b1; // Stop bit
                            state <= TX_STOP;
                        end else begin
                            o_tx    <= shreg[0];
                            bit_idx <= bit_idx + bit_idx_t'(1);
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end)
                        state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && i_tx_strobe)
            shreg <= i_tx_byte;
        else if ((state == TX_START || state == TX_DATA) && bit_end)
            shreg <= shreg >> 1;
    end

    a_no_strobe_busy : assert property (@(posedge i_clk) disable iff (i_reset)
        i_tx_strobe |-> !o_tx_busy);

endmodule

// File: debug_cmd_regs.sv
`timescale 1ns/1ps

module debug_cmd_regs
    import uart_pkg::*;
#(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_mode_set,
    input  logic                  i_mode_value,
    input  logic                  i_step_req,
    input  logic                  i_addr_load,
    input  uart_byte_t            i_addr_byte,
    output logic                  o_mode,
    output logic [ADDR_WIDTH-1:0] o_debug_addr,
    output logic                  o_step
);

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_mode       <= 1'b0; // Continuous run
            o_debug_addr <= '0;
            o_step       <= 1'b0;
        end else begin
            if (i_mode_set)
                o_mode <= i_mode_value;
            if (i_addr_load)
                o_debug_addr <= i_addr_byte[ADDR_WIDTH-1:0];
            // Step requests in run mode are dropped
            o_step <= i_step_req && o_mode;
        end
    end

    a_step_in_step_mode : assert property (@(posedge i_clk) disable iff (i_reset)
        o_step |-> o_mode);

endmodule

// File: debug_controller.sv
`timescale 1ns/1ps

module debug_controller
    import uart_pkg::*;
    import debug_pkg::*;
#(
    parameter int NUM_REGISTERS = 32,
    parameter int IF_ID_SIZE    = 32,
    parameter int ID_EX_SIZE    = 129,
    parameter int EX_MEM_SIZE   = 77,
    parameter int MEM_WB_SIZE   = 71,
    parameter int ADDR_WIDTH    = 6
) (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_rx_strobe,
    input  uart_byte_t                            i_rx_byte,
    input  logic                                  i_tx_busy,
    input  logic [NUM_REGISTERS*$bits(word_t)-1:0] i_registers,
    input  logic [IF_ID_SIZE-1:0]                 i_if_id,
    input  logic [ID_EX_SIZE-1:0]                 i_id_ex,
    input  logic [EX_MEM_SIZE-1:0]                i_ex_mem,
    input  logic [MEM_WB_SIZE-1:0]                i_mem_wb,
    input  word_t                                 i_debug_data,
    output logic                                  o_tx_strobe,
    output uart_byte_t                            o_tx_byte,
    output logic                                  o_mode_set,
    output logic                                  o_mode_value,
    output logic                                  o_step_req,
    output logic                                  o_addr_load,
    output uart_byte_t                            o_addr_byte,
    output logic                                  o_inst_write,
    output logic [ADDR_WIDTH-1:0]                 o_write_addr,
    output word_t                                 o_write_data
);

    function automatic int max_of(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    localparam int REG_BYTES    = NUM_REGISTERS * WORD_BYTES;
    localparam int IF_ID_BYTES  = (IF_ID_SIZE + 7) / 8; // Zero padded to whole bytes
    localparam int ID_EX_BYTES  = (ID_EX_SIZE + 7) / 8;
    localparam int EX_MEM_BYTES = (EX_MEM_SIZE + 7) / 8;
    localparam int MEM_WB_BYTES = (MEM_WB_SIZE + 7) / 8;
    localparam int SNAP_BYTES   = max_of(max_of(max_of(REG_BYTES, IF_ID_BYTES),
                                                max_of(ID_EX_BYTES, EX_MEM_BYTES)),
                                         max_of(MEM_WB_BYTES, WORD_BYTES));
    localparam int SNAP_W = SNAP_BYTES * 8;
    localparam int CNT_W  = $clog2(SNAP_BYTES + 1);

    ctrl_state_t           state;
    cmd_t                  cmd;
    logic [SNAP_W-1:0]     snap;       // Snapshot shift register
    logic [CNT_W-1:0]      bytes_left;
    logic [1:0]            byte_idx;
    logic [ADDR_WIDTH-1:0] word_cnt;
    word_t                 word_buf;
    logic                  dump_go;
    logic [SNAP_W-1:0]     dump_vec;
    logic [CNT_W-1:0]      dump_len;
    logic                  send_now;
    logic                  word_done;

    assign cmd       = cmd_t'(i_rx_byte);
    assign send_now  = (state == SEND) && !i_tx_busy;
    assign word_done = (state == LOAD) && i_rx_strobe && (byte_idx == 2'd3);

    // Dump source and length select
    always_comb begin
        dump_go  = 1'b1;
        dump_vec = '0;
        dump_len = '0;
        case (cmd)
            CMD_DUMP_REGS: begin
                dump_vec = SNAP_W'(i_registers);
                dump_len = CNT_W'(REG_BYTES);
            end
            CMD_DUMP_IF_ID: begin
                dump_vec = SNAP_W'(i_if_id);
                dump_len = CNT_W'(IF_ID_BYTES);
            end
            CMD_DUMP_ID_EX: begin
                dump_vec = SNAP_W'(i_id_ex);
                dump_len = CNT_W'(ID_EX_BYTES);
            end
            CMD_DUMP_EX_MEM: begin
                dump_vec = SNAP_W'(i_ex_mem);
                dump_len = CNT_W'(EX_MEM_BYTES);
            end
            CMD_DUMP_MEM_WB: begin
                dump_vec = SNAP_W'(i_mem_wb);
                dump_len = CNT_W'(MEM_WB_BYTES);
            end
            CMD_DUMP_MEM: begin
                dump_vec = SNAP_W'(i_debug_data);
                dump_len = CNT_W'(WORD_BYTES);
            end
            default: dump_go = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state        <= IDLE;
            bytes_left   <= '0;
            byte_idx     <= '0;
            word_cnt     <= '0;
            o_tx_strobe  <= 1'b0;
            o_mode_set   <= 1'b0;
            o_step_req   <= 1'b0;
            o_addr_load  <= 1'b0;
            o_inst_write <= 1'b0;
        end else begin
            o_tx_strobe  <= 1'b0;
            o_mode_set   <= 1'b0;
            o_step_req   <= 1'b0;
            o_addr_load  <= 1'b0;
            o_inst_write <= word_done;
            case (state)
                IDLE: begin
                    if (i_rx_strobe && dump_go) begin
                        bytes_left <= dump_len;
                        state      <= SEND;
                    end else if (i_rx_strobe) begin
                        case (cmd)
                            CMD_LOAD_PROG: begin
                                byte_idx <= '0;
                                word_cnt <= '0;
                                state    <= LOAD;
                            end
                            CMD_MODE_RUN, CMD_MODE_STEP: o_mode_set <= 1'b1;
                            CMD_STEP:                    o_step_req <= 1'b1;
                            CMD_SET_ADDR:                state      <= GET_ADDR;
                            default: ; // Unknown codes ignored
                        endcase
                    end
                end
                SEND: begin
                    if (send_now) begin
                        o_tx_strobe <= 1'b1;
                        bytes_left  <= bytes_left - CNT_W'(1);
                        state       <= WAIT_TX;
                    end
                end
                WAIT_TX: begin
                    // Busy is still low in the strobe cycle
                    if (!o_tx_strobe && !i_tx_busy)
                        state <= (bytes_left == '0) ? IDLE : SEND;
                end
                GET_ADDR: begin
                    if (i_rx_strobe) begin
                        o_addr_load <= 1'b1;
                        state       <= IDLE;
                    end
                end
                LOAD: begin
                    if (i_rx_strobe)
                        byte_idx <= byte_idx + 2'd1;
                    if (word_done) begin
                        word_cnt <= word_cnt + ADDR_WIDTH'(1);
                        if (word_cnt == '1)
                            state <= IDLE; // Last word of the memory
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_rx_strobe && dump_go) begin
            snap <= dump_vec;
        end else if (send_now) begin
            o_tx_byte <= snap[7:0]; // LSB first
            snap      <= snap >> 8;
        end
        if (i_rx_strobe) begin
            o_mode_value <= (cmd == CMD_MODE_STEP);
            o_addr_byte  <= i_rx_byte;
            word_buf     <= {i_rx_byte, word_buf[31:8]};
        end
        if (word_done) begin
            o_write_data <= {i_rx_byte, word_buf[31:8]};
            o_write_addr <= word_cnt;
        end
    end

endmodule

// File: debug_unit.sv
`timescale 1ns/1ps

module debug_unit
    import uart_pkg::*;
    import debug_pkg::*;
#(
    parameter int NUM_REGISTERS = 32,
    parameter int IF_ID_SIZE    = 32,
    parameter int ID_EX_SIZE    = 129,
    parameter int EX_MEM_SIZE   = 77,
    parameter int MEM_WB_SIZE   = 71,
    parameter int ADDR_WIDTH    = 6,
    parameter int BAUD_DIV      = 326
) (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_uart_rx,
    output logic                                  o_uart_tx,
    input  logic [NUM_REGISTERS*$bits(word_t)-1:0] i_registers,
    input  logic [IF_ID_SIZE-1:0]                 i_if_id,
    input  logic [ID_EX_SIZE-1:0]                 i_id_ex,
    input  logic [EX_MEM_SIZE-1:0]                i_ex_mem,
    input  logic [MEM_WB_SIZE-1:0]                i_mem_wb,
    input  word_t                                 i_debug_data,
    output logic                                  o_mode,
    output logic                                  o_step,
    output logic [ADDR_WIDTH-1:0]                 o_debug_addr,
    output logic                                  o_inst_write,
    output logic [ADDR_WIDTH-1:0]                 o_write_addr,
    output word_t                                 o_write_data
);

    logic       tick;
    logic       rx_strobe;
    uart_byte_t rx_byte;
    logic       tx_strobe;
    uart_byte_t tx_byte;
    logic       tx_busy;
    logic       mode_set;
    logic       mode_value;
    logic       step_req;
    logic       addr_load;
    uart_byte_t addr_byte;

    uart_baud_gen #(
        .BAUD_DIV(BAUD_DIV)
    ) baud_gen_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx uart_rx_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_tick      (tick),
        .i_rx        (i_uart_rx),
        .o_rx_strobe (rx_strobe),
        .o_rx_byte   (rx_byte)
    );

    uart_tx uart_tx_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_tick      (tick),
        .i_tx_strobe (tx_strobe),
        .i_tx_byte   (tx_byte),
        .o_tx_busy   (tx_busy),
        .o_tx        (o_uart_tx)
    );

    debug_controller #(
        .NUM_REGISTERS (NUM_REGISTERS),
        .IF_ID_SIZE    (IF_ID_SIZE),
        .ID_EX_SIZE    (ID_EX_SIZE),
        .EX_MEM_SIZE   (EX_MEM_SIZE),
        .MEM_WB_SIZE   (MEM_WB_SIZE),
        .ADDR_WIDTH    (ADDR_WIDTH)
    ) controller_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_strobe  (rx_strobe),
        .i_rx_byte    (rx_byte),
        .i_tx_busy    (tx_busy),
        .i_registers  (i_registers),
        .i_if_id      (i_if_id),
        .i_id_ex      (i_id_ex),
        .i_ex_mem     (i_ex_mem),
        .i_mem_wb     (i_mem_wb),
        .i_debug_data (i_debug_data),
        .o_tx_strobe  (tx_strobe),
        .o_tx_byte    (tx_byte),
        .o_mode_set   (mode_set),
        .o_mode_value (mode_value),
        .o_step_req   (step_req),
        .o_addr_load  (addr_load),
        .o_addr_byte  (addr_byte),
        .o_inst_write (o_inst_write),
        .o_write_addr (o_write_addr),
        .o_write_data (o_write_data)
    );

    debug_cmd_regs #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) cmd_regs_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_mode_set   (mode_set),
        .i_mode_value (mode_value),
        .i_step_req   (step_req),
        .i_addr_load  (addr_load),
        .i_addr_byte  (addr_byte),
        .o_mode       (o_mode),
        .o_debug_addr (o_debug_addr),
        .o_step       (o_step)
    );

endmodule

// File: tb_debug_checks.sv
`timescale 1ns/1ps

module tb_debug_checks
    import uart_pkg::*;
    import debug_pkg::*;
#(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_rx_strobe,   // Receiver strobe inside the DUT
    input  uart_byte_t            i_rx_byte,
    input  logic                  i_cmd_byte,    // Host is sending a byte meant as a command
    input  logic                  i_uart_tx,
    input  logic                  i_mode,
    input  logic                  i_step,
    input  logic                  i_inst_write,
    input  logic [ADDR_WIDTH-1:0] i_write_addr,
    input  word_t                 i_write_data,
    input  logic [ADDR_WIDTH-1:0] i_exp_waddr,
    input  word_t                 i_exp_word,
    output logic                  o_fail,
    output int                    o_step_count,
    output int                    o_write_count
);

    logic cmd_seen;

    assign cmd_seen = i_cmd_byte && i_rx_strobe;

    initial o_fail = 1'b0;

    task automatic flag_error(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $error("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
        o_fail = 1'b1;
    endtask

    // Idle line, run mode and no strobes right after reset
    a_reset_state : assert property (@(posedge i_clk)
        $fell(i_reset) |-> i_uart_tx && !i_mode && !i_step && !i_inst_write)
        else flag_error("{o_uart_tx,o_mode,o_step,o_inst_write}",
                        {i_uart_tx, i_mode, i_step, i_inst_write}, 4'b1000);

    a_mode_step : assert property (@(posedge i_clk) disable iff (i_reset)
        cmd_seen && i_rx_byte == CMD_MODE_STEP |-> ##2 i_mode)
        else flag_error("o_mode", i_mode, 1);

    a_mode_run : assert property (@(posedge i_clk) disable iff (i_reset)
        cmd_seen && i_rx_byte == CMD_MODE_RUN |-> ##2 !i_mode)
        else flag_error("o_mode", i_mode, 0);

    // Step pulse lands two cycles after the strobe, only in step mode
    a_step_pulse : assert property (@(posedge i_clk) disable iff (i_reset)
        cmd_seen && i_rx_byte == CMD_STEP && i_mode |-> ##2 i_step)
        else flag_error("o_step", i_step, 1);

    a_no_step_run : assert property (@(posedge i_clk) disable iff (i_reset)
        cmd_seen && i_rx_byte == CMD_STEP && !i_mode |-> ##2 !i_step)
        else flag_error("o_step", i_step, 0);

    a_step_single : assert property (@(posedge i_clk) disable iff (i_reset)
        i_step |=> !i_step)
        else flag_error("o_step", i_step, 0);

    a_step_requested : assert property (@(posedge i_clk) disable iff (i_reset)
        i_step |-> $past(cmd_seen && i_rx_byte == CMD_STEP, 2))
        else flag_error("o_step without step command", i_step, 0);

    a_write_after_strobe : assert property (@(posedge i_clk) disable iff (i_reset)
        i_inst_write |-> $past(i_rx_strobe))
        else flag_error("o_inst_write one cycle after strobe", i_inst_write, 0);

    // Program words and pulse counts
    always @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            o_step_count  <= 0;
            o_write_count <= 0;
        end else begin
            if (i_step)
                o_step_count <= o_step_count + 1;
            if (i_inst_write) begin
                assert (i_write_addr == i_exp_waddr)
                    else flag_error("o_write_addr", i_write_addr, i_exp_waddr);
                assert (i_write_data == i_exp_word)
                    else flag_error("o_write_data", i_write_data, i_exp_word);
                o_write_count <= o_write_count + 1;
            end
        end
    end

endmodule

// File: tb_debug_unit.sv
`timescale 1ns/1ps

module tb_debug_unit
    import uart_pkg::*;
    import debug_pkg::*;
();

    localparam int REGS       = 8;
    localparam int IF_ID_W    = 32;
    localparam int ID_EX_W    = 129;
    localparam int EX_MEM_W   = 77;
    localparam int MEM_WB_W   = 71;
    localparam int ADDR_W     = 4;
    localparam int BAUD_DIV   = 1;
    localparam int BIT_CLKS   = OVERSAMPLE * BAUD_DIV;
    localparam int FRAME_CLKS = 10 * BIT_CLKS;
    localparam int WORDS      = 1 << ADDR_W;

    // Frames on either line over the whole run, plus quiet windows after dumps
    localparam int DUMP_FRAMES = 2 * REGS * 4 + 2 * ((IF_ID_W + 7) / 8) + (ID_EX_W + 7) / 8
                                 + (EX_MEM_W + 7) / 8 + (MEM_WB_W + 7) / 8 + 4;
    localparam int HOST_FRAMES    = 20 + 4 * WORDS;
    localparam int QUIET_FRAMES   = 2 * 9;
    localparam int TIMEOUT_CYCLES = (DUMP_FRAMES + HOST_FRAMES + QUIET_FRAMES) * FRAME_CLKS
                                    + 1000;

    logic                   clk;
    logic                   reset;
    logic                   uart_rx_line;
    logic                   uart_tx;
    logic [REGS*32-1:0]     registers;
    logic [IF_ID_W-1:0]     if_id;
    logic [ID_EX_W-1:0]     id_ex;
    logic [EX_MEM_W-1:0]    ex_mem;
    logic [MEM_WB_W-1:0]    mem_wb;
    word_t                  debug_data;
    logic                   mode;
    logic                   step;
    logic [ADDR_W-1:0]      debug_addr;
    logic                   inst_write;
    logic [ADDR_W-1:0]      write_addr;
    word_t                  write_data;
    logic                   cmd_byte;
    logic [ADDR_W-1:0]      exp_waddr;
    word_t                  exp_word;
    logic                   check_failed;
    int                     step_count;
    int                     write_count;
    int                     cycle_cnt;
    logic [15:0]            lfsr;
    uart_byte_t             rx_q[$]; // Bytes seen on the tx line

    debug_unit #(
        .NUM_REGISTERS (REGS),
        .IF_ID_SIZE    (IF_ID_W),
        .ID_EX_SIZE    (ID_EX_W),
        .EX_MEM_SIZE   (EX_MEM_W),
        .MEM_WB_SIZE   (MEM_WB_W),
        .ADDR_WIDTH    (ADDR_W),
        .BAUD_DIV      (BAUD_DIV)
    ) debug_unit_i (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_uart_rx    (uart_rx_line),
        .o_uart_tx    (uart_tx),
        .i_registers  (registers),
        .i_if_id      (if_id),
        .i_id_ex      (id_ex),
        .i_ex_mem     (ex_mem),
        .i_mem_wb     (mem_wb),
        .i_debug_data (debug_data),
        .o_mode       (mode),
        .o_step       (step),
        .o_debug_addr (debug_addr),
        .o_inst_write (inst_write),
        .o_write_addr (write_addr),
        .o_write_data (write_data)
    );

    tb_debug_checks #(
        .ADDR_WIDTH(ADDR_W)
    ) checks_i (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_rx_strobe   (debug_unit_i.rx_strobe),
        .i_rx_byte     (debug_unit_i.rx_byte),
        .i_cmd_byte    (cmd_byte),
        .i_uart_tx     (uart_tx),
        .i_mode        (mode),
        .i_step        (step),
        .i_inst_write  (inst_write),
        .i_write_addr  (write_addr),
        .i_write_data  (write_data),
        .i_exp_waddr   (exp_waddr),
        .i_exp_word    (exp_word),
        .o_fail        (check_failed),
        .o_step_count  (step_count),
        .o_write_count (write_count)
    );

    always #4 clk = ~clk;

    task automatic report_failure(input string why);
        if (why != "")
            $display("%s", why);
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
            report_failure("");
        end
    endtask

    // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb)
            s = s ^ 16'hB400;
        return s;
    endfunction

    task automatic fill_random(output logic [255:0] v, input int nbits);
        v = '0; // Bits above nbits stay zero
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    // Host serial writer; start bit, 8 data bits LSB first, stop bit
    task automatic send_byte(input uart_byte_t b, input logic decode);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        @(posedge clk);
        cmd_byte <= decode;
        for (int i = 0; i < 10; i++) begin
            uart_rx_line <= frame[i];
            repeat (BIT_CLKS) @(posedge clk);
        end
        cmd_byte <= 1'b0;
    endtask

    // Sends a dump command, optionally with noise bytes during the reply
    task automatic check_dump(input uart_byte_t cmd, input logic [255:0] vec,
                              input int width, input int noise);
        int n;
        n = (width + 7) / 8;
        rx_q.delete();
        send_byte(cmd, 1'b1);
        for (int i = 0; i < noise; i++)
            send_byte((i == 0) ? 8'h0B : 8'h03, 1'b0);
        while (rx_q.size() < n)
            @(posedge clk);
        repeat (2 * FRAME_CLKS) @(posedge clk); // Nothing more may follow
        check_value("dump byte count", rx_q.size(), n);
        for (int i = 0; i < n; i++)
            check_value($sformatf("o_uart_tx byte %0d", i), rx_q[i], vec[8*i +: 8]);
    endtask

    // Host serial reader, samples each bit at its middle
    initial begin : serial_reader
        uart_byte_t b;
        forever begin
            @(posedge clk);
            if (!reset && !uart_tx) begin
                repeat (BIT_CLKS / 2) @(posedge clk);
                if (uart_tx)
                    report_failure("start bit on the tx line was too short");
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(posedge clk);
                    b = {uart_tx, b[7:1]};
                end
                repeat (BIT_CLKS) @(posedge clk);
                if (!uart_tx)
                    report_failure("missing stop bit on the tx line");
                rx_q.push_back(b);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            report_failure("timeout, the DUT did not finish all transfers in time");
    end

    always @(posedge check_failed)
        report_failure("a checker assertion reported an error");

    initial begin : stimulus
        logic [255:0] regs_v;
        logic [255:0] if_id_v;
        logic [255:0] id_ex_v;
        logic [255:0] ex_mem_v;
        logic [255:0] mem_wb_v;
        logic [255:0] mem_v;
        logic [255:0] word_v;
        clk          = 1'b0;
        reset        = 1'b1;
        uart_rx_line = 1'b1; // Idle line
        registers    = '0;
        if_id        = '0;
        id_ex        = '0;
        ex_mem       = '0;
        mem_wb       = '0;
        debug_data   = '0;
        cmd_byte     = 1'b0;
        exp_waddr    = '0;
        exp_word     = '0;
        cycle_cnt    = 0;
        lfsr         = 16'd3482;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        fill_random(regs_v, REGS * 32);
        fill_random(if_id_v, IF_ID_W);
        fill_random(id_ex_v, ID_EX_W);
        fill_random(ex_mem_v, EX_MEM_W);
        fill_random(mem_wb_v, MEM_WB_W);
        @(posedge clk);
        registers <= regs_v[REGS*32-1:0];
        if_id     <= if_id_v[IF_ID_W-1:0];
        id_ex     <= id_ex_v[ID_EX_W-1:0];
        ex_mem    <= ex_mem_v[EX_MEM_W-1:0];
        mem_wb    <= mem_wb_v[MEM_WB_W-1:0];
        check_dump(CMD_DUMP_REGS, regs_v, REGS * 32, 0);
        check_dump(CMD_DUMP_IF_ID, if_id_v, IF_ID_W, 0);
        check_dump(CMD_DUMP_ID_EX, id_ex_v, ID_EX_W, 0);
        check_dump(CMD_DUMP_EX_MEM, ex_mem_v, EX_MEM_W, 0);
        check_dump(CMD_DUMP_MEM_WB, mem_wb_v, MEM_WB_W, 0);

        // Step request in run mode, then one step in step mode
        send_byte(CMD_STEP, 1'b1);
        repeat (4) @(posedge clk);
        send_byte(CMD_MODE_STEP, 1'b1);
        repeat (4) @(posedge clk);
        check_value("o_mode", mode, 1);
        send_byte(CMD_STEP, 1'b1);
        repeat (4) @(posedge clk);
        send_byte(CMD_MODE_RUN, 1'b1);
        repeat (4) @(posedge clk);
        check_value("o_mode", mode, 0);

        send_byte(CMD_SET_ADDR, 1'b1);
        send_byte(8'h5C, 1'b0);
        repeat (4) @(posedge clk);
        check_value("o_debug_addr", debug_addr, 8'h5C % WORDS);
        fill_random(mem_v, 32);
        @(posedge clk);
        debug_data <= mem_v[31:0];
        check_dump(CMD_DUMP_MEM, mem_v, 32, 0);

        send_byte(CMD_LOAD_PROG, 1'b1);
        for (int w = 0; w < WORDS; w++) begin
            fill_random(word_v, 32);
            exp_waddr <= ADDR_W'(w);
            exp_word  <= word_v[31:0];
            for (int k = 0; k < 4; k++)
                send_byte(word_v[8*k +: 8], 1'b0);
        end
        repeat (4) @(posedge clk);
        check_value("o_inst_write pulses", write_count, WORDS);

        // Unknown code, then noise bytes during a dump
        rx_q.delete();
        send_byte(8'h3F, 1'b1);
        repeat (2 * FRAME_CLKS) @(posedge clk);
        check_value("tx bytes after unknown code", rx_q.size(), 0);
        check_value("o_mode", mode, 0);
        check_dump(CMD_DUMP_REGS, regs_v, REGS * 32, 2);
        check_value("o_debug_addr", debug_addr, 8'h5C % WORDS);
        check_dump(CMD_DUMP_IF_ID, if_id_v, IF_ID_W, 0);
        check_value("o_step pulses", step_count, 1);
        check_value("o_inst_write pulses", write_count, WORDS);

        @(posedge clk);
        if (check_failed) begin
            report_failure("a checker assertion reported an error");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// File: project.f
uart_pkg.sv
debug_pkg.sv
uart_baud_gen.sv
uart_rx.sv
uart_tx.sv
debug_cmd_regs.sv
debug_controller.sv
debug_unit.sv
tb_debug_checks.sv
tb_debug_unit.sv
